// ==== design/icache_defs.svh ====
// I-cache fetch subsystem widths
// address split, block size and memory bus tag
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ------------------------------
// fetch address split
// ------------------------------

// full fetch address
`define ICACHE_ADDR_W		32

// byte offset inside an 8-byte block
`define ICACHE_BLK_OFFSET_W	3

// set index, 32 sets
`define ICACHE_IDX_W		5

// what is left above index and offset
`define ICACHE_TAG_W		24

// ------------------------------
// block and memory bus
// ------------------------------
`define ICACHE_DATA_W		64

// zero means no response or no data
`define MEM_TAG_W			4

`endif

// ==== design/icache_pkg.sv ====
// shared types for the I-cache fetch subsystem
// bus command, controller state, bus request and cache fill/read structs
`include "icache_defs.svh"

package icache_pkg;

	// ------------------------------
	// enums
	// ------------------------------

	// memory bus command
	typedef enum logic [1:0] {
		BUS_NONE = 2'h0,
		BUS_LOAD = 2'h1
	} bus_cmd_t;

	// miss handling states of the controller
	typedef enum logic [2:0] {
		IDLE  = 3'h0,
		FETCH = 3'h1,
		WAIT  = 3'h2
	} ictrl_state_t;

	// ------------------------------
	// structs
	// ------------------------------

	// one request toward the memory bus
	typedef struct packed {
		bus_cmd_t					cmd;
		logic [`ICACHE_ADDR_W-1:0]	addr;
	} imem_req_t;

	// fill intent of one requester, data joins in the arbiter
	typedef struct packed {
		logic						wr_en;
		logic [`ICACHE_IDX_W-1:0]	idx;
		logic [`ICACHE_TAG_W-1:0]	tag;
	} cache_fill_t;

	// lookup result
	typedef struct packed {
		logic						hit;
		logic [`ICACHE_DATA_W-1:0]	data;
	} cache_rd_t;

endpackage

// ==== design/icache_mem.sv ====
// direct-mapped instruction cache array
// combinational lookup, block fill on the clock edge
`timescale 1ns/1ns
`include "icache_defs.svh"

module icache_mem
	import icache_pkg::*;
(
	input  logic						clk,
	input  logic						rst,

	// lookup from the controller
	input  logic [`ICACHE_IDX_W-1:0]	rd_idx_i,
	input  logic [`ICACHE_TAG_W-1:0]	rd_tag_i,

	// fill from the arbiter
	input  cache_fill_t					fill_i,
	input  logic [`ICACHE_DATA_W-1:0]	fill_data_i,

	output cache_rd_t					rd_o
);

	localparam int NUM_SETS = 1 << `ICACHE_IDX_W;

	// per set storage
	logic [`ICACHE_TAG_W-1:0]	tag_mem [NUM_SETS];
	logic [`ICACHE_DATA_W-1:0]	data_mem [NUM_SETS];
	logic [NUM_SETS-1:0]		valid_r;

	// ------------------------------
	// lookup
	// ------------------------------

	// hit needs a valid set and a matching tag
	assign rd_o.hit  = valid_r[rd_idx_i] && (tag_mem[rd_idx_i] == rd_tag_i);
	// block goes out regardless, hit qualifies it
	assign rd_o.data = data_mem[rd_idx_i];

	// ------------------------------
	// fill
	// ------------------------------

	// valid bits, all sets empty after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_r <= '0;
		end else if (fill_i.wr_en) begin
			valid_r[fill_i.idx] <= 1'b1;
		end
	end

	// tag and block written together
	always_ff @(posedge clk) begin
		if (fill_i.wr_en) begin
			tag_mem[fill_i.idx]  <= fill_i.tag;
			data_mem[fill_i.idx] <= fill_data_i;
		end
	end

endmodule

// ==== design/icache_ctrl.sv ====
// I-cache controller
// serves the fetch port, handles misses on the tagged memory bus and drives fills
`timescale 1ns/1ns
`include "icache_defs.svh"

module icache_ctrl
	import icache_pkg::*;
(
	input  logic							clk,
	input  logic							rst,

	// fetch stage
	input  logic [`ICACHE_ADDR_W-1:0]		if_addr_i,
	input  logic							if_req_i,
	// wrong branch prediction
	input  logic							if_flush_i,

	input  cache_rd_t						cache_rd_i,
	input  logic							pfetch_hit_i,

	// memory bus, response tag comes only when granted
	input  logic [`MEM_TAG_W-1:0]			mem_rsp_tag_i,
	input  logic [`MEM_TAG_W-1:0]			mem_data_tag_i,

	output logic							if_vld_o,
	output logic [`ICACHE_DATA_W-1:0]		if_data_o,

	output logic [`ICACHE_IDX_W-1:0]		rd_idx_o,
	output logic [`ICACHE_TAG_W-1:0]		rd_tag_o,
	output cache_fill_t						fill_o,

	output logic [`ICACHE_ADDR_W-1:0]		pfetch_addr_o,
	output logic							pfetch_en_o,

	output imem_req_t						mem_req_o
);

	ictrl_state_t					state_r, state_nxt;

	// outstanding memory tag, zero when none
	logic [`MEM_TAG_W-1:0]			tag_r, tag_nxt;

	logic [`ICACHE_TAG_W-1:0]		addr_tag;
	logic [`ICACHE_IDX_W-1:0]		addr_idx;
	logic							mem_ack;
	logic							data_rdy;

	// ------------------------------
	// address split and lookup
	// ------------------------------
	// offset bits are dropped, block granularity only
	assign {addr_tag, addr_idx} = if_addr_i[`ICACHE_ADDR_W-1:`ICACHE_BLK_OFFSET_W];
	assign rd_tag_o = addr_tag;
	assign rd_idx_o = addr_idx;

	// hit answers in the request cycle
	assign if_vld_o  = if_req_i && cache_rd_i.hit;
	assign if_data_o = cache_rd_i.data;

	// load accepted / our data is on the bus
	assign mem_ack  = (mem_rsp_tag_i != '0);
	assign data_rdy = (tag_r != '0) && (mem_data_tag_i == tag_r);

	// fill the missed set when our tag returns
	assign fill_o.wr_en = (state_r == WAIT) && data_rdy;
	assign fill_o.idx   = addr_idx;
	assign fill_o.tag   = addr_tag;

	// prefetcher follows the fetch stream, held off while we load
	assign pfetch_addr_o = if_addr_i;
	assign pfetch_en_o   = if_req_i && (state_r != FETCH);

	// block aligned load, only in FETCH
	assign mem_req_o.cmd  = (state_r == FETCH) ? BUS_LOAD : BUS_NONE;
	assign mem_req_o.addr = {addr_tag, addr_idx, {`ICACHE_BLK_OFFSET_W{1'b0}}};

	// ------------------------------
	// next state and tag
	// ------------------------------
	always_comb begin
		state_nxt = state_r;
		tag_nxt   = tag_r;
		case (state_r)
			IDLE: begin
				tag_nxt = '0;
				if (!if_flush_i && if_req_i && !cache_rd_i.hit) begin
					// prefetcher already loading this block
					state_nxt = pfetch_hit_i ? WAIT : FETCH;
				end
			end
			FETCH: begin
				if (if_flush_i) begin
					state_nxt = IDLE;
					tag_nxt   = '0;
				end else if (mem_ack) begin
					// keep the tag the memory gave us
					state_nxt = WAIT;
					tag_nxt   = mem_rsp_tag_i;
				end
			end
			WAIT: begin
				if (if_flush_i || data_rdy) begin
					tag_nxt = '0;
				end
				// the filled block shows up as a hit one cycle later
				if (if_flush_i || cache_rd_i.hit) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
				tag_nxt   = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= IDLE;
			tag_r   <= '0;
		end else begin
			state_r <= state_nxt;
			tag_r   <= tag_nxt;
		end
	end

endmodule

// ==== design/icache_prefetch.sv ====
// next-line prefetcher
// keeps one block load in flight and tells the controller when a miss hits it
`timescale 1ns/1ns
`include "icache_defs.svh"

module icache_prefetch
	import icache_pkg::*;
(
	input  logic						clk,
	input  logic						rst,

	// fetch address and enable from the controller
	input  logic [`ICACHE_ADDR_W-1:0]	pfetch_addr_i,
	input  logic						pfetch_en_i,

	input  logic [`MEM_TAG_W-1:0]		mem_rsp_tag_i,
	input  logic [`MEM_TAG_W-1:0]		mem_data_tag_i,

	output imem_req_t					mem_req_o,
	output cache_fill_t					fill_o,
	output logic						pfetch_hit_o
);

	localparam int BLK_W = `ICACHE_ADDR_W - `ICACHE_BLK_OFFSET_W;

	// in flight flag and its memory tag
	logic						busy_r;
	logic [`MEM_TAG_W-1:0]		tag_r;
	// last block loaded, still the in-flight one while busy
	logic [BLK_W-1:0]			blk_r;
	logic						blk_vld_r;

	logic [BLK_W-1:0]			fetch_blk;
	logic [BLK_W-1:0]			nxt_blk;
	logic						issue;
	logic						data_rdy;

	// ------------------------------
	// request
	// ------------------------------
	assign fetch_blk = pfetch_addr_i[`ICACHE_ADDR_W-1:`ICACHE_BLK_OFFSET_W];
	assign nxt_blk   = fetch_blk + 1'b1;

	// one at a time, never the same block twice in a row
	assign issue = pfetch_en_i && !busy_r && !(blk_vld_r && (nxt_blk == blk_r));

	assign mem_req_o.cmd  = issue ? BUS_LOAD : BUS_NONE;
	assign mem_req_o.addr = {nxt_blk, {`ICACHE_BLK_OFFSET_W{1'b0}}};

	// miss on the block we are loading
	assign pfetch_hit_o = busy_r && (fetch_blk == blk_r);

	// ------------------------------
	// fill
	// ------------------------------
	assign data_rdy = busy_r && (mem_data_tag_i == tag_r);

	assign fill_o.wr_en = data_rdy;
	assign {fill_o.tag, fill_o.idx} = blk_r;

	// in-flight tracking
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_r    <= 1'b0;
			tag_r     <= '0;
			blk_vld_r <= 1'b0;
		end else if (data_rdy) begin
			busy_r <= 1'b0;
			tag_r  <= '0;
		end else if (issue && (mem_rsp_tag_i != '0)) begin
			// accepted, tag is ours until the data comes back
			busy_r    <= 1'b1;
			tag_r     <= mem_rsp_tag_i;
			blk_vld_r <= 1'b1;
		end
	end

	// block address of the accepted load
	always_ff @(posedge clk) begin
		if (issue && (mem_rsp_tag_i != '0)) begin
			blk_r <= nxt_blk;
		end
	end

endmodule

// ==== design/imem_arbiter.sv ====
// memory bus arbiter for controller and prefetcher
// controller first on requests, returned block goes with the matching fill
`timescale 1ns/1ns
`include "icache_defs.svh"

module imem_arbiter
	import icache_pkg::*;
(
	// requesters
	input  imem_req_t					ctrl_req_i,
	input  imem_req_t					pfetch_req_i,
	input  cache_fill_t					ctrl_fill_i,
	input  cache_fill_t					pfetch_fill_i,

	// memory side
	input  logic [`MEM_TAG_W-1:0]		mem_rsp_tag_i,
	input  logic [`ICACHE_DATA_W-1:0]	mem_data_i,
	output imem_req_t					mem_req_o,

	// acceptance back to each requester
	output logic [`MEM_TAG_W-1:0]		ctrl_rsp_tag_o,
	output logic [`MEM_TAG_W-1:0]		pfetch_rsp_tag_o,

	// to the cache
	output cache_fill_t					fill_o,
	output logic [`ICACHE_DATA_W-1:0]	fill_data_o
);

	logic	ctrl_gnt;
	logic	pfetch_gnt;

	// ------------------------------
	// request side
	// ------------------------------
	assign ctrl_gnt   = (ctrl_req_i.cmd == BUS_LOAD);
	assign pfetch_gnt = !ctrl_gnt && (pfetch_req_i.cmd == BUS_LOAD);

	assign mem_req_o = ctrl_gnt ? ctrl_req_i : pfetch_req_i;

	// loser never sees the tag, so it keeps asking
	assign ctrl_rsp_tag_o   = ctrl_gnt ? mem_rsp_tag_i : '0;
	assign pfetch_rsp_tag_o = pfetch_gnt ? mem_rsp_tag_i : '0;

	// ------------------------------
	// fill side
	// ------------------------------
	// tags are unique, so at most one wr_en is high
	assign fill_o      = ctrl_fill_i.wr_en ? ctrl_fill_i : pfetch_fill_i;
	assign fill_data_o = mem_data_i;

endmodule

// ==== design/icache_top.sv ====
// instruction fetch subsystem top
// cache array, controller, prefetcher and bus arbiter around one memory bus
`timescale 1ns/1ns
`include "icache_defs.svh"

module icache_top
	import icache_pkg::*;
(
	input  logic						clk,
	input  logic						rst,

	// fetch port
	input  logic [`ICACHE_ADDR_W-1:0]	if_addr_i,
	input  logic						if_req_i,
	input  logic						if_flush_i,
	output logic						if_vld_o,
	output logic [`ICACHE_DATA_W-1:0]	if_data_o,

	// tagged memory bus
	output imem_req_t					mem_req_o,
	input  logic [`MEM_TAG_W-1:0]		mem_rsp_tag_i,
	input  logic [`MEM_TAG_W-1:0]		mem_data_tag_i,
	input  logic [`ICACHE_DATA_W-1:0]	mem_data_i
);

	// cache lookup and fill
	logic [`ICACHE_IDX_W-1:0]		rd_idx;
	logic [`ICACHE_TAG_W-1:0]		rd_tag;
	cache_rd_t						cache_rd;
	cache_fill_t					fill;
	logic [`ICACHE_DATA_W-1:0]		fill_data;

	// controller <-> prefetcher
	logic [`ICACHE_ADDR_W-1:0]		pfetch_addr;
	logic							pfetch_en;
	logic							pfetch_hit;

	// per requester bus signals
	imem_req_t						ctrl_req, pfetch_req;
	cache_fill_t					ctrl_fill, pfetch_fill;
	logic [`MEM_TAG_W-1:0]			ctrl_rsp_tag, pfetch_rsp_tag;

	icache_mem u_mem (
		.clk         (clk),
		.rst         (rst),
		.rd_idx_i    (rd_idx),
		.rd_tag_i    (rd_tag),
		.fill_i      (fill),
		.fill_data_i (fill_data),
		.rd_o        (cache_rd)
	);

	icache_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.if_addr_i      (if_addr_i),
		.if_req_i       (if_req_i),
		.if_flush_i     (if_flush_i),
		.cache_rd_i     (cache_rd),
		.pfetch_hit_i   (pfetch_hit),
		.mem_rsp_tag_i  (ctrl_rsp_tag),
		.mem_data_tag_i (mem_data_tag_i),
		.if_vld_o       (if_vld_o),
		.if_data_o      (if_data_o),
		.rd_idx_o       (rd_idx),
		.rd_tag_o       (rd_tag),
		.fill_o         (ctrl_fill),
		.pfetch_addr_o  (pfetch_addr),
		.pfetch_en_o    (pfetch_en),
		.mem_req_o      (ctrl_req)
	);

	icache_prefetch u_prefetch (
		.clk            (clk),
		.rst            (rst),
		.pfetch_addr_i  (pfetch_addr),
		.pfetch_en_i    (pfetch_en),
		.mem_rsp_tag_i  (pfetch_rsp_tag),
		.mem_data_tag_i (mem_data_tag_i),
		.mem_req_o      (pfetch_req),
		.fill_o         (pfetch_fill),
		.pfetch_hit_o   (pfetch_hit)
	);

	// shared bus, both requesters see the raw data tag
	imem_arbiter u_arb (
		.ctrl_req_i       (ctrl_req),
		.pfetch_req_i     (pfetch_req),
		.ctrl_fill_i      (ctrl_fill),
		.pfetch_fill_i    (pfetch_fill),
		.mem_rsp_tag_i    (mem_rsp_tag_i),
		.mem_data_i       (mem_data_i),
		.mem_req_o        (mem_req_o),
		.ctrl_rsp_tag_o   (ctrl_rsp_tag),
		.pfetch_rsp_tag_o (pfetch_rsp_tag),
		.fill_o           (fill),
		.fill_data_o      (fill_data)
	);

endmodule

// ==== testbench/imem_model.sv ====
// tagged memory model for the fetch subsystem testbench
// accepts loads with rolling tags and returns each block a fixed time later
`timescale 1ns/1ns
`include "icache_defs.svh"

module imem_model
	import icache_pkg::*;
#(
	parameter int			LATENCY = 6,
	parameter int unsigned	SEED    = 32'h1
) (
	input  logic						clk,
	input  logic						rst,
	input  imem_req_t					mem_req_i,
	output logic [`MEM_TAG_W-1:0]		mem_rsp_tag_o,
	output logic [`MEM_TAG_W-1:0]		mem_data_tag_o,
	output logic [`ICACHE_DATA_W-1:0]	mem_data_o
);

	localparam logic [`MEM_TAG_W-1:0] TAG_MAX = '1;

	// bus refused this cycle
	logic						refuse_r;
	logic [`MEM_TAG_W-1:0]		tag_cnt_r;
	int unsigned				cycle_cnt;

	// outstanding loads, oldest first
	logic [`MEM_TAG_W-1:0]		pend_tag [$];
	logic [`ICACHE_ADDR_W-1:0]	pend_addr [$];
	int unsigned				pend_due [$];

	// same cycle answer to a load
	assign mem_rsp_tag_o = (mem_req_i.cmd == BUS_LOAD && !refuse_r) ? tag_cnt_r : '0;

	initial begin : serve_loop
		int unsigned				seed;
		logic						accept;
		logic [`ICACHE_ADDR_W-1:0]	blk;
		seed           = SEED;
		void'($urandom(seed));
		refuse_r       = 1'b0;
		tag_cnt_r      = 1;
		cycle_cnt      = 0;
		mem_data_tag_o = '0;
		mem_data_o     = '0;
		forever begin
			@(posedge clk);
			// sample the bus before anything moves
			accept = !rst && (mem_rsp_tag_o != '0);
			blk    = {mem_req_i.addr[`ICACHE_ADDR_W-1:`ICACHE_BLK_OFFSET_W],
				{`ICACHE_BLK_OFFSET_W{1'b0}}};
			#1;
			cycle_cnt++;
			mem_data_tag_o = '0;
			if (accept) begin
				pend_tag.push_back(tag_cnt_r);
				pend_addr.push_back(blk);
				pend_due.push_back(cycle_cnt + LATENCY);
				// tags run 1..15, zero is reserved
				tag_cnt_r = (tag_cnt_r == TAG_MAX) ? 1 : tag_cnt_r + 1'b1;
			end
			// one return per cycle at most, loads are accepted one per cycle
			if (pend_due.size() > 0 && pend_due[0] == cycle_cnt) begin
				mem_data_tag_o = pend_tag.pop_front();
				blk            = pend_addr.pop_front();
				mem_data_o     = {~blk, blk};
				void'(pend_due.pop_front());
			end
			// one in four cycles the bus says no
			refuse_r = ($urandom % 4) == 0;
		end
	end

endmodule

// ==== testbench/icache_checker.sv ====
// controller protocol assertions
// attached to icache_ctrl with bind
`timescale 1ns/1ns

module icache_checker
	import icache_pkg::*;
(
	input  logic			clk,
	input  logic			rst,
	input  ictrl_state_t	state_i,
	input  imem_req_t		mem_req_i,
	input  logic			pfetch_en_i,
	input  cache_fill_t		fill_i
);

	// ------------------------------
	// bus command
	// ------------------------------

	// loads only while fetching
	load_in_fetch: assert property (@(posedge clk) disable iff (rst)
		(mem_req_i.cmd == BUS_LOAD) |-> (state_i == FETCH))
		else $error("controller drove a bus load outside FETCH");

	// quiet bus right after reset
	none_after_rst: assert property (@(posedge clk)
		rst |=> (mem_req_i.cmd == BUS_NONE))
		else $error("bus command not idle after reset");

	// ------------------------------
	// prefetch and fill
	// ------------------------------
	no_pfetch_in_fetch: assert property (@(posedge clk) disable iff (rst)
		(state_i == FETCH) |-> !pfetch_en_i)
		else $error("prefetch enabled while the controller loads");

	no_fill_in_idle: assert property (@(posedge clk) disable iff (rst)
		(state_i == IDLE) |-> !fill_i.wr_en)
		else $error("controller fill while idle");

endmodule

// ==== testbench/icache_tb.sv ====
// testbench for the instruction fetch subsystem
// file driven fetch and flush sequence against a tagged memory model
`timescale 1ns/1ns
`include "icache_defs.svh"

module icache_tb
	import icache_pkg::*;
();

	localparam int			MEM_LATENCY = 6;
	localparam int unsigned	SEED        = 32'h92a77665;
	localparam int			RST_CYCLES  = 8;
	localparam int			MAX_OPS     = 32;
	// op codes in the stimulus file
	localparam int			OP_FETCH    = 1;
	localparam int			OP_FLUSH    = 2;
	localparam int			OP_HIT      = 3;

	logic						clk;
	logic						rst;
	logic [`ICACHE_ADDR_W-1:0]	if_addr;
	logic						if_req;
	logic						if_flush;
	logic						if_vld;
	logic [`ICACHE_DATA_W-1:0]	if_data;
	imem_req_t					mem_req;
	logic [`MEM_TAG_W-1:0]		mem_rsp_tag;
	logic [`MEM_TAG_W-1:0]		mem_data_tag;
	logic [`ICACHE_DATA_W-1:0]	mem_data;

	// four words per stimulus line
	// op, fetch address, cycles before flush and expected block address
	logic [31:0]				stim_mem [0:4*MAX_OPS-1];
	int							n_ops;
	int							n_checks;
	int							n_errors;
	bit							ops_loaded;

	icache_top u_dut (
		.clk            (clk),
		.rst            (rst),
		.if_addr_i      (if_addr),
		.if_req_i       (if_req),
		.if_flush_i     (if_flush),
		.if_vld_o       (if_vld),
		.if_data_o      (if_data),
		.mem_req_o      (mem_req),
		.mem_rsp_tag_i  (mem_rsp_tag),
		.mem_data_tag_i (mem_data_tag),
		.mem_data_i     (mem_data)
	);

	imem_model #(.LATENCY(MEM_LATENCY), .SEED(SEED)) u_mem_model (
		.clk            (clk),
		.rst            (rst),
		.mem_req_i      (mem_req),
		.mem_rsp_tag_o  (mem_rsp_tag),
		.mem_data_tag_o (mem_data_tag),
		.mem_data_o     (mem_data)
	);

	bind icache_ctrl icache_checker u_checker (
		.clk         (clk),
		.rst         (rst),
		.state_i     (state_r),
		.mem_req_i   (mem_req_o),
		.pfetch_en_i (pfetch_en_o),
		.fill_i      (fill_o)
	);

	always #5 clk = ~clk;

	// ------------------------------
	// expected values and compares
	// ------------------------------

	// inverted block address on top, block address below
	function automatic logic [`ICACHE_DATA_W-1:0] expected_block(input logic [31:0] blk_addr);
		return {~blk_addr, blk_addr};
	endfunction

	task automatic compare_block(input logic [`ICACHE_DATA_W-1:0] exp_blk,
		input logic [`ICACHE_DATA_W-1:0] act_blk);
		n_checks++;
		if (act_blk !== exp_blk) begin
			n_errors++;
			$display("error if_data_o expected %h got %h at %0t", exp_blk, act_blk, $time);
		end
	endtask

	task automatic compare_vld(input logic exp_vld, input logic act_vld);
		n_checks++;
		if (act_vld !== exp_vld) begin
			n_errors++;
			$display("error if_vld_o expected %h got %h at %0t", exp_vld, act_vld, $time);
		end
	endtask

	// ------------------------------
	// fetch port operations
	// ------------------------------

	// hold the request until valid
	// hits must answer in the request cycle
	task automatic fetch_and_check(input logic [31:0] addr, input logic [31:0] blk_addr,
		input bit must_hit);
		@(posedge clk);
		#1;
		if_addr  = addr;
		if_req   = 1'b1;
		if_flush = 1'b0;
		@(negedge clk);
		if (must_hit)
			compare_vld(1'b1, if_vld);
		while (if_vld !== 1'b1)
			@(negedge clk);
		compare_block(expected_block(blk_addr), if_data);
	endtask

	// start a miss, then abandon it with a one cycle flush
	task automatic abandon_miss(input logic [31:0] addr, input int unsigned n_cyc);
		@(posedge clk);
		#1;
		if_addr = addr;
		if_req  = 1'b1;
		repeat (n_cyc) @(posedge clk);
		#1;
		if_req   = 1'b0;
		if_flush = 1'b1;
		@(posedge clk);
		#1;
		if_flush = 1'b0;
	endtask

	initial begin : main_seq
		int i;
		clk        = 1'b0;
		rst        = 1'b1;
		if_addr    = '0;
		if_req     = 1'b0;
		if_flush   = 1'b0;
		n_checks   = 0;
		n_errors   = 0;
		ops_loaded = 1'b0;
		for (i = 0; i < 4*MAX_OPS; i++)
			stim_mem[i] = '0;
		$readmemh("testbench/icache_stimulus.txt", stim_mem);
		// op zero ends the list
		n_ops = 0;
		while (n_ops < MAX_OPS && stim_mem[4*n_ops] != 0)
			n_ops++;
		ops_loaded = 1'b1;
		if (n_ops == 0) begin
			n_errors++;
			$display("no operations could be read from the stimulus file");
		end
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		for (i = 0; i < n_ops; i++) begin
			case (stim_mem[4*i])
				OP_FETCH: fetch_and_check(stim_mem[4*i+1], stim_mem[4*i+3], 1'b0);
				OP_HIT:   fetch_and_check(stim_mem[4*i+1], stim_mem[4*i+3], 1'b1);
				OP_FLUSH: abandon_miss(stim_mem[4*i+1], stim_mem[4*i+2]);
				default: begin
					n_errors++;
					$display("unknown operation %0d on stimulus line %0d", stim_mem[4*i], i);
				end
			endcase
		end
		@(posedge clk);
		#1;
		if_req = 1'b0;
		// let late data drain past the checker
		repeat (MEM_LATENCY + 4) @(posedge clk);
		$display("fetch checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// run limit scales with the stimulus length
	initial begin : watchdog
		int limit;
		wait (ops_loaded);
		limit = RST_CYCLES + (n_ops + 1) * (MEM_LATENCY + 20);
		repeat (limit) @(posedge clk);
		$display("hang: the fetch sequence did not finish within %0d cycles", limit);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== icache_fetch.f ====
+incdir+design
design/icache_pkg.sv
design/icache_mem.sv
design/icache_ctrl.sv
design/icache_prefetch.sv
design/imem_arbiter.sv
design/icache_top.sv
testbench/imem_model.sv
testbench/icache_checker.sv
testbench/icache_tb.sv

// ==== testbench/icache_stimulus.txt ====
// op (1 fetch, 2 fetch then flush, 3 fetch that must hit), fetch address,
// cycles before the flush, expected block address
1 00001044 00 00001040
3 00001040 00 00001040
1 00001048 00 00001048
1 00001050 00 00001050
3 0000104c 00 00001048
2 00002000 03 00000000
1 00003000 00 00003000
1 00002004 00 00002000
1 00005080 00 00005080
1 00006080 00 00006080
1 00005084 00 00005080
1 00006084 00 00006080
2 00007100 01 00000000
1 00007108 00 00007108
